//--- filelist.f
rtl/bridge_pkg.sv
rtl/wr_ctrl_fsm.sv
rtl/rd_ctrl_fsm.sv
rtl/beat_counter.sv
rtl/r_channel_reg.sv
rtl/axi_fifo_bridge.sv
dv/tb_clk_gen.sv
dv/tb_axi_fifo_bridge.sv

//--- Bender.yml
package:
  name: axi_fifo_bridge

sources:
  - files:
      - rtl/bridge_pkg.sv
      - rtl/wr_ctrl_fsm.sv
      - rtl/rd_ctrl_fsm.sv
      - rtl/beat_counter.sv
      - rtl/r_channel_reg.sv
      - rtl/axi_fifo_bridge.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_axi_fifo_bridge.sv

//--- dv/tb_axi_fifo_bridge.sv
`default_nettype none

module tb_axi_fifo_bridge import bridge_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Stimulus runs to roughly 1500 cycles at most
    localparam int MAX_CYCLES = 4000;
    localparam int TX_DEPTH   = 8;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } b_resp_t;

    logic s_axi_aclk;
    logic s_axi_aresetn;

    // DUT inputs
    logic [ADDR_W-1:0] s_axi_awaddr       = '0;
    logic [ID_W-1:0]   s_axi_awid         = '0;
    logic              s_axi_awvalid      = 1'b0;
    logic [DATA_W-1:0] s_axi_wdata        = '0;
    logic              s_axi_wvalid       = 1'b0;
    logic              s_axi_wlast        = 1'b0;
    logic              s_axi_bready       = 1'b0;
    logic [ADDR_W-1:0] s_axi_araddr       = '0;
    logic [ID_W-1:0]   s_axi_arid         = '0;
    logic [LEN_W-1:0]  s_axi_arlen        = '0;
    logic              s_axi_arvalid      = 1'b0;
    logic              s_axi_rready       = 1'b1;
    logic              rto_core_full      = 1'b0;
    logic [DATA_W-1:0] rti_core_fifo_dout = '0;
    logic              rti_core_empty     = 1'b1;
    logic [CNT_W-1:0]  data_num           = '0;

    // DUT outputs
    logic              s_axi_awready;
    logic              s_axi_wready;
    logic [ID_W-1:0]   s_axi_bid;
    logic [1:0]        s_axi_bresp;
    logic              s_axi_bvalid;
    logic              s_axi_arready;
    logic [ID_W-1:0]   s_axi_rid;
    logic [DATA_W-1:0] s_axi_rdata;
    logic [1:0]        s_axi_rresp;
    logic              s_axi_rlast;
    logic              s_axi_rvalid;
    logic              rto_core_write;
    logic [DATA_W-1:0] rto_core_fifo_din;
    logic              rto_core_flush;
    logic              rti_core_flush;
    logic              rti_core_rd_en;

    // Scoreboard
    r_beat_t           exp_r[$];
    b_resp_t           exp_b[$];
    logic [DATA_W-1:0] exp_tx[$];
    // Receive FIFO contents
    // Front word drives rti_core_fifo_dout
    logic [DATA_W-1:0] rx_q[$];
    // Data beats of the next write burst
    logic [DATA_W-1:0] wbeats[$];
    logic [ADDR_W-1:0] wr_addr      = '0;
    logic              exp_write    = 1'b0;
    logic              exp_tx_flush = 1'b0;
    logic              exp_rx_flush = 1'b0;
    bit                rready_random = 1'b0;
    int                tx_count    = 0;
    int                cycle_count = 0;

    tb_clk_gen u_clk_gen (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn)
    );

    axi_fifo_bridge dut0 (.*);

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Beat idx of a read from the queue as it stands at AR time
    function automatic r_beat_t predict_r_beat(input logic [ADDR_W-1:0] addr,
            input logic [ID_W-1:0] id, input int idx, input int len);
        r_beat_t beat;
        beat.id   = id;
        beat.data = '0;
        beat.resp = RESP_SLVERR;
        beat.last = 1'b1;
        if (addr == ADDR_FIFO) begin
            // Full burst with error beats once the queue runs dry
            beat.last = (idx == len);
            if (idx < rx_q.size()) begin
                beat.data = rx_q[idx];
                beat.resp = RESP_OKAY;
            end
        end else if (addr == ADDR_CTRL) begin
            beat.data = DATA_W'(rx_q.size());
            beat.resp = RESP_OKAY;
        end
        return beat;
    endfunction

    function automatic b_resp_t b_response_for(input logic [ADDR_W-1:0] addr,
            input logic [ID_W-1:0] id);
        b_resp_t resp;
        resp.id   = id;
        resp.resp = (addr == ADDR_FIFO || addr == ADDR_CTRL) ? RESP_OKAY : RESP_SLVERR;
        return resp;
    endfunction

    function automatic logic [DATA_W-1:0] random_word();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input logic [DATA_W-1:0] got,
            input logic [DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic load_rx_words(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            rx_q.push_back(random_word());
        end
        // FIFO model outputs catch up
        repeat (2) @(posedge s_axi_aclk);
    endtask

    task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id);
        int i;
        wr_addr = addr;
        exp_b.push_back(b_response_for(addr, id));
        if (addr == ADDR_FIFO) begin
            for (i = 0; i < wbeats.size(); i++) begin
                exp_tx.push_back(wbeats[i]);
            end
        end
        s_axi_awaddr  <= addr;
        s_axi_awid    <= id;
        s_axi_awvalid <= 1'b1;
        do @(posedge s_axi_aclk); while (!s_axi_awready);
        s_axi_awvalid <= 1'b0;
        for (i = 0; i < wbeats.size(); i++) begin
            s_axi_wdata  <= wbeats[i];
            s_axi_wlast  <= (i == wbeats.size() - 1);
            s_axi_wvalid <= 1'b1;
            do @(posedge s_axi_aclk); while (!s_axi_wready);
        end
        s_axi_wvalid <= 1'b0;
        s_axi_wlast  <= 1'b0;
        while (exp_b.size() != 0) @(posedge s_axi_aclk);
        repeat (2) @(posedge s_axi_aclk);
        wbeats.delete();
    endtask

    task automatic read_burst(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
            input int len);
        int beats;
        int i;
        beats = (addr == ADDR_FIFO) ? len + 1 : 1;
        for (i = 0; i < beats; i++) begin
            exp_r.push_back(predict_r_beat(addr, id, i, len));
        end
        s_axi_araddr  <= addr;
        s_axi_arid    <= id;
        s_axi_arlen   <= LEN_W'(len);
        s_axi_arvalid <= 1'b1;
        do @(posedge s_axi_aclk); while (!s_axi_arready);
        s_axi_arvalid <= 1'b0;
        while (exp_r.size() != 0) @(posedge s_axi_aclk);
        repeat (2) @(posedge s_axi_aclk);
    endtask

    ////////////////////////////////////////////////////////////
    // Core FIFO models and ready generators
    ////////////////////////////////////////////////////////////

    // Transmit FIFO model
    // Full flag counts the beat still on its way
    always @(posedge s_axi_aclk) begin
        logic pending;
        if (!s_axi_aresetn) begin
            tx_count = 0;
            rto_core_full <= 1'b0;
        end else begin
            if (rto_core_flush) begin
                tx_count = 0;
            end else if (rto_core_write) begin
                tx_count++;
            end
            if (tx_count > TX_DEPTH) begin
                $display("transmit FIFO model overflowed, the full flag was ignored");
                abort_run();
            end else begin
                // Core side drains a word now and then
                if (tx_count > 0 && $urandom_range(0, 3) == 0) begin
                    tx_count--;
                end
                pending = s_axi_wvalid && s_axi_wready && (wr_addr == ADDR_FIFO);
                rto_core_full <= (tx_count + int'(pending)) >= TX_DEPTH;
            end
        end
    end

    // Receive FIFO model with first word fall-through
    always @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn || rti_core_flush) begin
            rx_q.delete();
        end else if (rti_core_rd_en && rx_q.size() != 0) begin
            void'(rx_q.pop_front());
        end
        rti_core_empty     <= (rx_q.size() == 0);
        rti_core_fifo_dout <= (rx_q.size() != 0) ? rx_q[0] : '0;
        data_num           <= CNT_W'(rx_q.size());
    end

    always @(posedge s_axi_aclk) begin
        s_axi_bready <= ($urandom_range(0, 3) != 0);
        s_axi_rready <= rready_random ? ($urandom_range(0, 1) == 1) : 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Comparison and timeout
    ////////////////////////////////////////////////////////////

    always @(posedge s_axi_aclk) begin
        r_beat_t exp_beat;
        b_resp_t exp_resp;
        logic    w_fire;
        if (!s_axi_aresetn) begin
            exp_write    = 1'b0;
            exp_tx_flush = 1'b0;
            exp_rx_flush = 1'b0;
        end else begin
            // Strobes due from the beat of the previous edge
            compare_value(rto_core_write, exp_write, "transmit FIFO write strobe");
            compare_value(rto_core_flush, exp_tx_flush, "transmit FIFO flush");
            compare_value(rti_core_flush, exp_rx_flush, "receive FIFO flush");
            if (rto_core_write) begin
                if (exp_tx.size() == 0) begin
                    $display("transmit FIFO written with no word expected at %0d ns", $time);
                    abort_run();
                end else begin
                    compare_value(rto_core_fifo_din, exp_tx.pop_front(), "transmit word");
                end
            end
            if (s_axi_bvalid && s_axi_bready) begin
                if (exp_b.size() == 0) begin
                    $display("write response with no write outstanding at %0d ns", $time);
                    abort_run();
                end else begin
                    exp_resp = exp_b.pop_front();
                    compare_value(s_axi_bid, exp_resp.id, "bid");
                    compare_value(s_axi_bresp, exp_resp.resp, "bresp");
                end
            end
            if (s_axi_rvalid && s_axi_rready) begin
                if (exp_r.size() == 0) begin
                    $display("read beat with no read outstanding at %0d ns", $time);
                    abort_run();
                end else begin
                    exp_beat = exp_r.pop_front();
                    compare_value(s_axi_rid, exp_beat.id, "rid");
                    compare_value(s_axi_rdata, exp_beat.data, "rdata");
                    compare_value(s_axi_rresp, exp_beat.resp, "rresp");
                    compare_value(s_axi_rlast, exp_beat.last, "rlast");
                end
            end
            w_fire       = s_axi_wvalid && s_axi_wready;
            exp_write    = w_fire && (wr_addr == ADDR_FIFO);
            exp_tx_flush = w_fire && (wr_addr == ADDR_CTRL) && s_axi_wdata[0];
            exp_rx_flush = w_fire && (wr_addr == ADDR_CTRL) && s_axi_wdata[1];
        end
    end

    always @(posedge s_axi_aclk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int                i;
        logic [DATA_W-1:0] w;
        void'($urandom(32'h89ed_b73b));
        while (!s_axi_aresetn) @(posedge s_axi_aclk);
        @(posedge s_axi_aclk);
        // Idle outputs out of reset
        compare_value(s_axi_awready, 1'b1, "awready after reset");
        compare_value(s_axi_arready, 1'b1, "arready after reset");
        compare_value(s_axi_bvalid, 1'b0, "bvalid after reset");
        compare_value(s_axi_rvalid, 1'b0, "rvalid after reset");
        compare_value(rti_core_rd_en, 1'b0, "rti_core_rd_en after reset");

        // 12 beats into a model that fills at 8
        for (i = 0; i < 12; i++) begin
            wbeats.push_back(random_word());
        end
        write_burst(ADDR_FIFO, 16'h1a2b);

        // Flush combinations 0..3
        // Receive flush empties the queue
        load_rx_words(3);
        for (i = 0; i < 4; i++) begin
            w = random_word();
            w[1:0] = i[1:0];
            wbeats.push_back(w);
        end
        write_burst(ADDR_CTRL, 16'h0c01);
        read_burst(ADDR_CTRL, 16'h0c02, 0);

        // Unmapped write address
        wbeats.push_back(random_word());
        wbeats.push_back(random_word());
        write_burst(6'h20, 16'h0d20);

        // Exact fit and then a burst longer than the queue
        load_rx_words(6);
        read_burst(ADDR_FIFO, 16'h0e01, 5);
        load_rx_words(3);
        read_burst(ADDR_FIFO, 16'h0e02, 5);

        // Count, empty FIFO read and unmapped read
        load_rx_words(4);
        read_burst(ADDR_CTRL, 16'h0f01, 0);
        read_burst(ADDR_FIFO, 16'h0f02, 3);
        read_burst(ADDR_FIFO, 16'h0f03, 0);
        read_burst(6'h30, 16'h0f04, 2);

        // Random rready
        rready_random = 1'b1;
        load_rx_words(14);
        read_burst(ADDR_FIFO, 16'h1001, 3);
        read_burst(ADDR_FIFO, 16'h1002, 4);
        read_burst(ADDR_FIFO, 16'h1003, 2);
        compare_value(rx_q.size(), 2, "receive words left after back-pressure");
        read_burst(ADDR_CTRL, 16'h1004, 0);
        read_burst(ADDR_FIFO, 16'h1005, 3);
        compare_value(rx_q.size(), 0, "receive words left at the end");
        rready_random = 1'b0;
        repeat (4) @(posedge s_axi_aclk);

        if (exp_r.size() == 0 && exp_b.size() == 0 && exp_tx.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("transfers still outstanding when the stimulus ended");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic s_axi_aclk,
    output logic s_axi_aresetn
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        s_axi_aclk = 1'b0;
        forever begin
            #4 s_axi_aclk = ~s_axi_aclk;
        end
    end

    // Reset low over the first two rising edges
    initial begin
        s_axi_aresetn = 1'b0;
        repeat (2) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/axi_fifo_bridge.sv
`default_nettype none

module axi_fifo_bridge import bridge_pkg::*; (
    input  wire                s_axi_aclk,
    input  wire                s_axi_aresetn,
    // Write address
    input  wire   [ADDR_W-1:0] s_axi_awaddr,
    input  wire   [ID_W-1:0]   s_axi_awid,
    input  wire                s_axi_awvalid,
    output logic               s_axi_awready,
    // Write data
    input  wire   [DATA_W-1:0] s_axi_wdata,
    input  wire                s_axi_wvalid,
    input  wire                s_axi_wlast,
    output logic               s_axi_wready,
    // Write response
    input  wire                s_axi_bready,
    output logic  [ID_W-1:0]   s_axi_bid,
    output logic  [1:0]        s_axi_bresp,
    output logic               s_axi_bvalid,
    // Read address
    input  wire   [ADDR_W-1:0] s_axi_araddr,
    input  wire   [ID_W-1:0]   s_axi_arid,
    input  wire   [LEN_W-1:0]  s_axi_arlen,
    input  wire                s_axi_arvalid,
    output logic               s_axi_arready,
    // Read data
    input  wire                s_axi_rready,
    output logic  [ID_W-1:0]   s_axi_rid,
    output logic  [DATA_W-1:0] s_axi_rdata,
    output logic  [1:0]        s_axi_rresp,
    output logic               s_axi_rlast,
    output logic               s_axi_rvalid,
    // Transmit FIFO core
    input  wire                rto_core_full,
    output logic               rto_core_write,
    output logic  [DATA_W-1:0] rto_core_fifo_din,
    output logic               rto_core_flush,
    // Receive FIFO core
    input  wire   [DATA_W-1:0] rti_core_fifo_dout,
    input  wire                rti_core_empty,
    input  wire   [CNT_W-1:0]  data_num,
    output logic               rti_core_flush,
    output logic               rti_core_rd_en
);

    ////////////////////////////////////////////////////////////
    // Read path handshakes
    ////////////////////////////////////////////////////////////

    // Beat requests from the read FSM to the R register
    logic              beat_load;
    beat_src_e         beat_src;
    logic [ID_W-1:0]   beat_id;
    logic              beat_last;
    // R register can take a new beat this cycle
    logic              slot_free;
    // Burst length bookkeeping
    logic              cnt_load;
    logic              cnt_last;

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    wr_ctrl_fsm u_wr_ctrl (
        .s_axi_aclk        (s_axi_aclk),
        .s_axi_aresetn     (s_axi_aresetn),
        .s_axi_awaddr      (s_axi_awaddr),
        .s_axi_awid        (s_axi_awid),
        .s_axi_awvalid     (s_axi_awvalid),
        .s_axi_wdata       (s_axi_wdata),
        .s_axi_wvalid      (s_axi_wvalid),
        .s_axi_wlast       (s_axi_wlast),
        .s_axi_bready      (s_axi_bready),
        .rto_core_full     (rto_core_full),
        .s_axi_awready     (s_axi_awready),
        .s_axi_wready      (s_axi_wready),
        .s_axi_bid         (s_axi_bid),
        .s_axi_bresp       (s_axi_bresp),
        .s_axi_bvalid      (s_axi_bvalid),
        .rto_core_write    (rto_core_write),
        .rto_core_fifo_din (rto_core_fifo_din),
        .rto_core_flush    (rto_core_flush),
        .rti_core_flush    (rti_core_flush)
    );

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    rd_ctrl_fsm u_rd_ctrl (
        .s_axi_aclk     (s_axi_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arid     (s_axi_arid),
        .s_axi_arvalid  (s_axi_arvalid),
        .rti_core_empty (rti_core_empty),
        .slot_free      (slot_free),
        .cnt_last       (cnt_last),
        .s_axi_arready  (s_axi_arready),
        .cnt_load       (cnt_load),
        .beat_load      (beat_load),
        .beat_src       (beat_src),
        .beat_id        (beat_id),
        .beat_last      (beat_last),
        .rti_core_rd_en (rti_core_rd_en)
    );

    beat_counter u_beat_counter (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .cnt_load      (cnt_load),
        .s_axi_arlen   (s_axi_arlen),
        .beat_load     (beat_load),
        .cnt_last      (cnt_last)
    );

    // Output stage of the R channel
    r_channel_reg u_r_reg (
        .s_axi_aclk         (s_axi_aclk),
        .s_axi_aresetn      (s_axi_aresetn),
        .beat_load          (beat_load),
        .beat_src           (beat_src),
        .beat_id            (beat_id),
        .beat_last          (beat_last),
        .rti_core_fifo_dout (rti_core_fifo_dout),
        .data_num           (data_num),
        .s_axi_rready       (s_axi_rready),
        .slot_free          (slot_free),
        .s_axi_rid          (s_axi_rid),
        .s_axi_rdata        (s_axi_rdata),
        .s_axi_rresp        (s_axi_rresp),
        .s_axi_rlast        (s_axi_rlast),
        .s_axi_rvalid       (s_axi_rvalid)
    );

endmodule

`default_nettype wire

//--- rtl/r_channel_reg.sv
`default_nettype none

module r_channel_reg import bridge_pkg::*; (
    input  wire                s_axi_aclk,
    input  wire                s_axi_aresetn,
    input  wire                beat_load,
    input  beat_src_e          beat_src,
    input  wire   [ID_W-1:0]   beat_id,
    input  wire                beat_last,
    input  wire   [DATA_W-1:0] rti_core_fifo_dout,
    input  wire   [CNT_W-1:0]  data_num,
    input  wire                s_axi_rready,
    output logic               slot_free,
    output logic  [ID_W-1:0]   s_axi_rid,
    output logic  [DATA_W-1:0] s_axi_rdata,
    output logic  [1:0]        s_axi_rresp,
    output logic               s_axi_rlast,
    output logic               s_axi_rvalid
);

    // Empty, or the held beat leaves this cycle
    assign slot_free = !s_axi_rvalid || s_axi_rready;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_rvalid <= 1'b0;
        end else if (beat_load) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Beat payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (beat_load) begin
            s_axi_rid   <= beat_id;
            s_axi_rlast <= beat_last;
            case (beat_src)
                SRC_FIFO: begin
                    s_axi_rdata <= rti_core_fifo_dout;
                    s_axi_rresp <= RESP_OKAY;
                end
                SRC_COUNT: begin
                    // Count zero-extended into the low bits
                    s_axi_rdata <= {{(DATA_W-CNT_W){1'b0}}, data_num};
                    s_axi_rresp <= RESP_OKAY;
                end
                default: begin
                    s_axi_rdata <= '0;
                    s_axi_rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

    // Held beat must not change under back-pressure
    a_r_stable: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=>
            s_axi_rvalid && $stable(s_axi_rid) && $stable(s_axi_rdata) &&
            $stable(s_axi_rresp) && $stable(s_axi_rlast)
    );

endmodule

`default_nettype wire

//--- rtl/beat_counter.sv
`default_nettype none

module beat_counter import bridge_pkg::*; (
    input  wire               s_axi_aclk,
    input  wire               s_axi_aresetn,
    input  wire               cnt_load,
    input  wire   [LEN_W-1:0] s_axi_arlen,
    input  wire               beat_load,
    output logic              cnt_last
);

    // Beats still to load minus one
    logic [LEN_W-1:0] remain;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            remain <= '0;
        end else if (cnt_load) begin
            remain <= s_axi_arlen;
        end else if (beat_load && !cnt_last) begin
            remain <= remain - 1'b1;
        end
    end

    // One beat left
    assign cnt_last = (remain == '0);

    // No further beat requested once the final one is loaded
    a_no_underflow: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        beat_load && cnt_last |=> !beat_load
    );

endmodule

`default_nettype wire

//--- rtl/rd_ctrl_fsm.sv
`default_nettype none

module rd_ctrl_fsm import bridge_pkg::*; (
    input  wire                s_axi_aclk,
    input  wire                s_axi_aresetn,
    input  wire   [ADDR_W-1:0] s_axi_araddr,
    input  wire   [ID_W-1:0]   s_axi_arid,
    input  wire                s_axi_arvalid,
    input  wire                rti_core_empty,
    input  wire                slot_free,
    input  wire                cnt_last,
    output logic               s_axi_arready,
    output logic               cnt_load,
    output logic               beat_load,
    output beat_src_e          beat_src,
    output logic  [ID_W-1:0]   beat_id,
    output logic               beat_last,
    output logic               rti_core_rd_en
);

    rd_state_e state;
    // Source of the one beat in RD_SINGLE
    beat_src_e single_src;

    logic ar_fire;

    ////////////////////////////////////////////////////////////
    // Address channel
    ////////////////////////////////////////////////////////////

    assign s_axi_arready = (state == RD_IDLE);
    assign ar_fire       = s_axi_arvalid && s_axi_arready;
    // Length loaded on every request
    // Single beats then count down from arlen as well
    assign cnt_load      = ar_fire;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        state <= (s_axi_araddr == ADDR_FIFO) ? RD_BURST : RD_SINGLE;
                    end
                end
                RD_BURST: begin
                    // Leave once the final beat is in the R register
                    if (beat_load && cnt_last) begin
                        state <= RD_IDLE;
                    end
                end
                RD_SINGLE: begin
                    if (beat_load) begin
                        state <= RD_IDLE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // Request fields kept for the whole burst
    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            beat_id    <= s_axi_arid;
            single_src <= (s_axi_araddr == ADDR_CTRL) ? SRC_COUNT : SRC_ERROR;
        end
    end

    ////////////////////////////////////////////////////////////
    // Beat issue
    ////////////////////////////////////////////////////////////

    always_comb begin
        beat_load = 1'b0;
        beat_src  = SRC_ERROR;
        beat_last = 1'b0;
        case (state)
            RD_BURST: begin
                beat_load = slot_free;
                // Empty receive FIFO gives an error beat
                beat_src  = rti_core_empty ? SRC_ERROR : SRC_FIFO;
                beat_last = cnt_last;
            end
            RD_SINGLE: begin
                beat_load = slot_free;
                beat_src  = single_src;
                beat_last = 1'b1;
            end
            default: begin
                beat_load = 1'b0;
            end
        endcase
    end

    // Pop in the cycle the FWFT word is captured
    assign rti_core_rd_en = beat_load && (beat_src == SRC_FIFO);

    a_no_pop_when_empty: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rti_core_rd_en |-> !rti_core_empty
    );

endmodule

`default_nettype wire

//--- rtl/wr_ctrl_fsm.sv
`default_nettype none

module wr_ctrl_fsm import bridge_pkg::*; (
    input  wire                s_axi_aclk,
    input  wire                s_axi_aresetn,
    input  wire   [ADDR_W-1:0] s_axi_awaddr,
    input  wire   [ID_W-1:0]   s_axi_awid,
    input  wire                s_axi_awvalid,
    input  wire   [DATA_W-1:0] s_axi_wdata,
    input  wire                s_axi_wvalid,
    input  wire                s_axi_wlast,
    input  wire                s_axi_bready,
    input  wire                rto_core_full,
    output logic               s_axi_awready,
    output logic               s_axi_wready,
    output logic  [ID_W-1:0]   s_axi_bid,
    output logic  [1:0]        s_axi_bresp,
    output logic               s_axi_bvalid,
    output logic               rto_core_write,
    output logic  [DATA_W-1:0] rto_core_fifo_din,
    output logic               rto_core_flush,
    output logic               rti_core_flush
);

    wr_state_e state;
    // Burst type picked from the write address
    wr_state_e aw_target;

    logic aw_fire;
    logic w_fire;
    logic push_fire;
    logic flush_fire;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    // New address only taken between bursts
    assign s_axi_awready = (state == WR_IDLE);
    // Push stalls on a full transmit FIFO
    // Flush and drain beats are always taken
    assign s_axi_wready  = ((state == WR_PUSH) && !rto_core_full) ||
                           (state == WR_FLUSH) || (state == WR_DRAIN);
    // Response held for the whole WR_RESP state
    assign s_axi_bvalid  = (state == WR_RESP);

    assign aw_fire    = s_axi_awvalid && s_axi_awready;
    assign w_fire     = s_axi_wvalid && s_axi_wready;
    assign push_fire  = w_fire && (state == WR_PUSH);
    assign flush_fire = w_fire && (state == WR_FLUSH);

    // Address decode
    always_comb begin
        if (s_axi_awaddr == ADDR_FIFO) begin
            aw_target = WR_PUSH;
        end else if (s_axi_awaddr == ADDR_CTRL) begin
            aw_target = WR_FLUSH;
        end else begin
            aw_target = WR_DRAIN;
        end
    end

    ////////////////////////////////////////////////////////////
    // State and core strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state          <= WR_IDLE;
            rto_core_write <= 1'b0;
            rto_core_flush <= 1'b0;
            rti_core_flush <= 1'b0;
        end else begin
            // One-cycle strobes after each accepted beat
            rto_core_write <= push_fire;
            rto_core_flush <= flush_fire && s_axi_wdata[0];
            rti_core_flush <= flush_fire && s_axi_wdata[1];

            case (state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        state <= aw_target;
                    end
                end
                WR_PUSH, WR_FLUSH, WR_DRAIN: begin
                    // Burst ends on wlast, awlen is not tracked
                    if (w_fire && s_axi_wlast) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (s_axi_bready) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        // ID and response code fixed at address time
        if (aw_fire) begin
            s_axi_bid   <= s_axi_awid;
            s_axi_bresp <= (aw_target == WR_DRAIN) ? RESP_SLVERR : RESP_OKAY;
        end
        // Data lines up with the registered write strobe
        if (push_fire) begin
            rto_core_fifo_din <= s_axi_wdata;
        end
    end

    // Full flag seen one cycle earlier blocks the write strobe
    a_no_write_after_full: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rto_core_full |=> !rto_core_write
    );

    // Response stays up until the master takes it
    a_bvalid_hold: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid
    );

endmodule

`default_nettype wire

//--- rtl/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    // AXI address, only the low 6 bits are decoded
    localparam int ADDR_W = 6;
    localparam int DATA_W = 128;
    localparam int ID_W   = 16;
    // AXI4 burst length field
    localparam int LEN_W  = 8;
    // Word count reported by the receive FIFO core
    localparam int CNT_W  = 10;

    ////////////////////////////////////////////////////////////
    // Address map and responses
    ////////////////////////////////////////////////////////////

    // FIFO data window for both directions
    localparam logic [ADDR_W-1:0] ADDR_FIFO = 6'h00;
    // Flush control on write, word count on read
    localparam logic [ADDR_W-1:0] ADDR_CTRL = 6'h10;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    ////////////////////////////////////////////////////////////
    // State and beat source encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_PUSH,
        WR_FLUSH,
        WR_DRAIN,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_BURST,
        RD_SINGLE
    } rd_state_e;

    // Where the payload of one R beat comes from
    typedef enum logic [1:0] {
        SRC_FIFO,
        SRC_COUNT,
        SRC_ERROR
    } beat_src_e;

endpackage

`default_nettype wire
